// ==== build.f ====
common/merge_pkg.sv
design/stream_fifo.sv
merger/merge_control.sv
merger/merge_pipe.sv
merger/stream_merger.sv
testbench/merge_checker.sv
testbench/tb_stream_merger.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_stream_merger

sim_out=$(./obj_dir/Vtb_stream_merger)
echo "$sim_out"

if echo "$sim_out" | grep -q "all tests passed"; then
   exit 0
fi
exit 1

// ==== testbench/tb_stream_merger.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_stream_merger;
   import merge_pkg::*;

   localparam int NROWS = 6;
   localparam int TIMEOUT = 2000;
   localparam int STALL_CYCLES = 200;
   localparam int READY_ALWAYS = 0;
   localparam int READY_RANDOM = 1;
   localparam int READY_STALL = 2;

   // Keys of all rows back to back. A zero closes a run, and the start tables mark the rows.
   localparam int A_KEYS [55] = '{3, 8, 15, 40, 0, 10, 20, 20, 0, 0, 4, 6, 0,
      2, 4, 6, 8, 10, 12, 14, 16, 18, 20, 22, 24, 26, 28, 30, 32, 34, 36, 38, 40,
      42, 44, 46, 48, 50, 52, 54, 56, 58, 60, 0,
      1, 1, 5, 9, 13, 0, 7, 0, 100, 200, 0};
   localparam int B_KEYS [56] = '{5, 9, 30, 0, 10, 20, 35, 0, 2, 9, 11, 0, 0,
      1, 3, 5, 7, 9, 11, 13, 15, 17, 19, 21, 23, 25, 27, 29, 31, 33, 35, 37, 39,
      41, 43, 45, 47, 49, 51, 53, 55, 57, 59, 0,
      1, 2, 6, 0, 3, 8, 0, 50, 150, 250, 300, 0};
   localparam int A_START [NROWS+1] = '{0, 5, 9, 13, 44, 52, 55};
   localparam int B_START [NROWS+1] = '{0, 4, 8, 13, 44, 51, 56};
   localparam int A_GAPS [NROWS] = '{0, 0, 0, 0, 1, 1};
   localparam int B_GAPS [NROWS] = '{0, 0, 0, 1, 1, 0};
   localparam int READY_MODE [NROWS] = '{READY_ALWAYS, READY_ALWAYS, READY_ALWAYS,
      READY_STALL, READY_RANDOM, READY_RANDOM};

   logic clk = 1'b0;
   logic rst_n = 1'b0;
   tuple_t a_data = '0;
   tuple_t b_data = '0;
   logic a_empty = 1'b1;
   logic b_empty = 1'b1;
   logic out_ready = 1'b0;
   logic a_read;
   logic b_read;
   logic out_write;
   tuple_t out_data;
   logic running = 1'b0;
   logic end_check = 1'b0;
   int row = 0;
   int a_idx = 0;
   int b_idx = 0;
   int a_gap = 0;
   int b_gap = 0;
   int cyc = 0;
   int out_count;
   int mismatches;
   int protocol_errors;

   // The upper half tags each tuple with its source, row and index.
   function automatic tuple_t tag_tuple(input int src, input int r, input int idx, input int key);
      return {src[0], r[14:0], idx[15:0], key};
   endfunction

   // Each pair of runs loses one of its two sentinels.
   function automatic int merged_length(input int r);
      int runs;
      runs = 0;
      for (int i = A_START[r]; i < A_START[r+1]; i++) begin
         if (A_KEYS[i] == 0) begin
            runs++;
         end
      end
      return (A_START[r+1] - A_START[r]) + (B_START[r+1] - B_START[r]) - runs;
   endfunction

   stream_merger u_stream_merger (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_a_data    (a_data),
      .i_a_empty   (a_empty),
      .o_a_read    (a_read),
      .i_b_data    (b_data),
      .i_b_empty   (b_empty),
      .o_b_read    (b_read),
      .i_out_ready (out_ready),
      .o_out_write (out_write),
      .o_out_data  (out_data)
   );

   merge_checker u_merge_checker (
      .i_clk             (clk),
      .i_rst_n           (rst_n),
      .i_a_data          (a_data),
      .i_a_empty         (a_empty),
      .i_a_read          (a_read),
      .i_b_data          (b_data),
      .i_b_empty         (b_empty),
      .i_b_read          (b_read),
      .i_out_ready       (out_ready),
      .i_out_write       (out_write),
      .i_out_data        (out_data),
      .i_end             (end_check),
      .o_out_count       (out_count),
      .o_mismatches      (mismatches),
      .o_protocol_errors (protocol_errors)
   );

   initial begin
      forever #5 clk = ~clk;
   end

   // Source models show their head like a FWFT FIFO and step on each accepted read.
   always @(posedge clk) begin
      if (!running) begin
         a_idx = 0;
         b_idx = 0;
         a_gap = 0;
         b_gap = 0;
         cyc = 0;
         a_empty <= 1'b1;
         b_empty <= 1'b1;
         out_ready <= 1'b1;
      end else begin
         if (a_read && !a_empty) begin
            a_idx++;
            a_gap = A_GAPS[row] ? $urandom_range(3, 0) : 0;
         end
         if (b_read && !b_empty) begin
            b_idx++;
            b_gap = B_GAPS[row] ? $urandom_range(3, 0) : 0;
         end
         if (a_gap > 0) begin
            a_gap--;
            a_empty <= 1'b1;
         end else if (a_idx < A_START[row+1] - A_START[row]) begin
            a_empty <= 1'b0;
            a_data <= tag_tuple(0, row, a_idx, A_KEYS[A_START[row] + a_idx]);
         end else begin
            a_empty <= 1'b1;
         end
         if (b_gap > 0) begin
            b_gap--;
            b_empty <= 1'b1;
         end else if (b_idx < B_START[row+1] - B_START[row]) begin
            b_empty <= 1'b0;
            b_data <= tag_tuple(1, row, b_idx, B_KEYS[B_START[row] + b_idx]);
         end else begin
            b_empty <= 1'b1;
         end
         case (READY_MODE[row])
            READY_RANDOM: out_ready <= 1'($urandom_range(1, 0));
            READY_STALL:  out_ready <= (cyc >= STALL_CYCLES);
            default:      out_ready <= 1'b1;
         endcase
         cyc++;
      end
   end

   initial begin
      int cycles;
      int expected_total;
      int timeouts;
      expected_total = 0;
      timeouts = 0;
      void'($urandom(32'hd91c));
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      for (int r = 0; r < NROWS && timeouts == 0; r++) begin
         expected_total += merged_length(r);
         @(posedge clk);
         row <= r;
         running <= 1'b1;
         cycles = 0;
         while (out_count < expected_total && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
         end
         if (out_count < expected_total) begin
            timeouts++;
            $display("Timeout in row %0d after %0d cycles, %0d of %0d tuples out",
                     r, cycles, out_count, expected_total);
         end
         @(posedge clk);
         running <= 1'b0;
      end
      // Idle cycles give any extra output a chance to show up.
      repeat (20) @(posedge clk);
      end_check <= 1'b1;
      repeat (2) @(posedge clk);
      $display("Errors: %0d mismatches, %0d protocol errors, %0d timeouts",
               mismatches, protocol_errors, timeouts);
      if (mismatches + protocol_errors + timeouts == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/merge_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module merge_checker
   import merge_pkg::*;
(
   input  wire logic   i_clk,
   input  wire logic   i_rst_n,
   input  wire tuple_t i_a_data,
   input  wire logic   i_a_empty,
   input  wire logic   i_a_read,
   input  wire tuple_t i_b_data,
   input  wire logic   i_b_empty,
   input  wire logic   i_b_read,
   input  wire logic   i_out_ready,
   input  wire logic   i_out_write,
   input  wire tuple_t i_out_data,
   input  wire logic   i_end,
   output int          o_out_count,
   output int          o_mismatches,
   output int          o_protocol_errors
);

   // Ready low this long means both input buffers or sources must have stopped.
   localparam int STALL_LIMIT = 150;

   tuple_t a_q[$];
   tuple_t b_q[$];
   tuple_t exp_q[$];
   tuple_t expected;
   logic ready_q = 1'b0;
   logic idle_check = 1'b1;
   logic end_checked = 1'b0;
   int low_cycles = 0;
   int writes = 0;
   int mismatches = 0;
   int protocol_errors = 0;

   // Moves tuples from the recorded inputs into the expected output while both heads exist.
   task automatic merge_heads();
      key_t ka;
      key_t kb;
      while (a_q.size() > 0 && b_q.size() > 0) begin
         ka = a_q[0][KEY_W-1:0];
         kb = b_q[0][KEY_W-1:0];
         if (ka == '0 && kb == '0) begin
            exp_q.push_back('0);
            void'(a_q.pop_front());
            void'(b_q.pop_front());
         end else if (kb == '0 || (ka != '0 && ka <= kb)) begin
            exp_q.push_back(a_q.pop_front());
         end else begin
            exp_q.push_back(b_q.pop_front());
         end
      end
   endtask

   always @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         a_q.delete();
         b_q.delete();
         exp_q.delete();
         idle_check = 1'b1;
         low_cycles = 0;
         ready_q <= 1'b0;
      end else begin
         if (idle_check && (i_a_read || i_b_read || i_out_write)) begin
            protocol_errors++;
            $display("Read or write strobe high right after reset at %0t", $time);
         end
         idle_check = 1'b0;
         if (i_a_read && !i_a_empty) begin
            a_q.push_back(i_a_data);
         end
         if (i_b_read && !i_b_empty) begin
            b_q.push_back(i_b_data);
         end
         merge_heads();
         if (i_out_write) begin
            writes++;
            if (!ready_q) begin
               protocol_errors++;
               $display("Output write while the registered ready was low at %0t", $time);
            end
            if (exp_q.size() == 0) begin
               protocol_errors++;
               $display("Unexpected output tuple %h at %0t", i_out_data, $time);
            end else begin
               expected = exp_q.pop_front();
               if (i_out_data !== expected) begin
                  mismatches++;
                  $display("MISMATCH time=%0t signal=o_out_data expected=%h actual=%h",
                           $time, expected, i_out_data);
               end
            end
         end
         low_cycles = ready_q ? 0 : low_cycles + 1;
         if (low_cycles == STALL_LIMIT && (i_a_read || i_b_read)) begin
            protocol_errors++;
            $display("Upstream reads still active during a long stall at %0t", $time);
         end
         if (i_end && !end_checked) begin
            end_checked = 1'b1;
            if (a_q.size() + b_q.size() + exp_q.size() != 0) begin
               protocol_errors++;
               $display("Tuples never came out: %0d expected outputs left", exp_q.size());
            end
         end
         ready_q <= i_out_ready;
      end
      o_out_count <= writes;
      o_mismatches <= mismatches;
      o_protocol_errors <= protocol_errors;
   end

endmodule

`default_nettype wire

// ==== merger/stream_merger.sv ====
`timescale 1ns/100ps
`default_nettype none

module stream_merger
   import merge_pkg::*;
(
   input  wire logic   i_clk,
   input  wire logic   i_rst_n,
   input  wire tuple_t i_a_data,
   input  wire logic   i_a_empty,
   output logic        o_a_read,
   input  wire tuple_t i_b_data,
   input  wire logic   i_b_empty,
   output logic        o_b_read,
   input  wire logic   i_out_ready,
   output logic        o_out_write,
   output tuple_t      o_out_data
);

   tuple_t a_head;
   tuple_t b_head;
   tuple_t pipe_data;
   logic a_empty;
   logic a_full;
   logic b_empty;
   logic b_full;
   logic out_empty;
   logic out_almost_full;
   logic a_pop;
   logic b_pop;
   logic pipe_write;
   logic out_ready_q;
   sel_e sel;

   // The downstream ready is taken one cycle late.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_ready_q <= 1'b0;
      end else begin
         out_ready_q <= i_out_ready;
      end
   end

   assign o_a_read = !i_a_empty && !a_full;
   assign o_b_read = !i_b_empty && !b_full;
   assign o_out_write = out_ready_q && !out_empty;

   stream_fifo u_fifo_a (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_enq         (o_a_read),
      .i_data        (i_a_data),
      .i_deq         (a_pop),
      .o_data        (a_head),
      .o_empty       (a_empty),
      .o_full        (a_full),
      .o_almost_full ()
   );

   stream_fifo u_fifo_b (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_enq         (o_b_read),
      .i_data        (i_b_data),
      .i_deq         (b_pop),
      .o_data        (b_head),
      .o_empty       (b_empty),
      .o_full        (b_full),
      .o_almost_full ()
   );

   merge_control u_merge_control (
      .i_a_head          (a_head),
      .i_a_empty         (a_empty),
      .i_b_head          (b_head),
      .i_b_empty         (b_empty),
      .i_out_almost_full (out_almost_full),
      .o_a_pop           (a_pop),
      .o_b_pop           (b_pop),
      .o_sel             (sel)
   );

   merge_pipe u_merge_pipe (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_sel    (sel),
      .i_a_head (a_head),
      .i_b_head (b_head),
      .o_write  (pipe_write),
      .o_data   (pipe_data)
   );

   // Almost-full leaves room for the tuples still in the pipe.
   stream_fifo u_fifo_out (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_enq         (pipe_write),
      .i_data        (pipe_data),
      .i_deq         (o_out_write),
      .o_data        (o_out_data),
      .o_empty       (out_empty),
      .o_full        (),
      .o_almost_full (out_almost_full)
   );

endmodule

`default_nettype wire

// ==== merger/merge_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module merge_pipe
   import merge_pkg::*;
(
   input  wire logic   i_clk,
   input  wire logic   i_rst_n,
   input  wire sel_e   i_sel,
   input  wire tuple_t i_a_head,
   input  wire tuple_t i_b_head,
   output logic        o_write,
   output tuple_t      o_data
);

   tuple_t pick;
   tuple_t s1_data;
   tuple_t s2_data;
   logic s1_valid;
   logic s2_valid;

   // SEL_END emits an all-zero sentinel.
   always_comb begin
      case (i_sel)
         SEL_A:   pick = i_a_head;
         SEL_B:   pick = i_b_head;
         default: pick = '0;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         s1_valid <= (i_sel != SEL_NONE);
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      s1_data <= pick;
      s2_data <= s1_data;
   end

   assign o_write = s2_valid;
   assign o_data = s2_data;

endmodule

`default_nettype wire

// ==== merger/merge_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module merge_control
   import merge_pkg::*;
(
   input  wire tuple_t i_a_head,
   input  wire logic   i_a_empty,
   input  wire tuple_t i_b_head,
   input  wire logic   i_b_empty,
   input  wire logic   i_out_almost_full,
   output logic        o_a_pop,
   output logic        o_b_pop,
   output sel_e        o_sel
);

   key_t key_a;
   key_t key_b;
   logic a_zero;
   logic b_zero;
   logic a_lte_b;
   logic can_go;

   assign key_a = i_a_head[KEY_W-1:0];
   assign key_b = i_b_head[KEY_W-1:0];

   // A zero key is the sentinel that closes a run.
   assign a_zero = (key_a == '0);
   assign b_zero = (key_b == '0);
   assign a_lte_b = (key_a <= key_b);

   // Both heads are needed before anything can be compared.
   assign can_go = !i_out_almost_full && !i_a_empty && !i_b_empty;

   always_comb begin
      o_sel = SEL_NONE;
      if (can_go) begin
         if (a_zero && b_zero) begin
            o_sel = SEL_END;
         end else if (a_zero) begin
            // Run A is done, so B drains until its own sentinel.
            o_sel = SEL_B;
         end else if (b_zero) begin
            o_sel = SEL_A;
         end else if (a_lte_b) begin
            o_sel = SEL_A;
         end else begin
            o_sel = SEL_B;
         end
      end
   end

   // On SEL_END both sentinels are consumed and a single one is emitted.
   assign o_a_pop = (o_sel == SEL_A) || (o_sel == SEL_END);
   assign o_b_pop = (o_sel == SEL_B) || (o_sel == SEL_END);

endmodule

`default_nettype wire

// ==== design/stream_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module stream_fifo
   import merge_pkg::*;
#(
   parameter int DEPTH = FIFO_DEPTH,
   parameter int AW = FIFO_AW
) (
   input  wire logic   i_clk,
   input  wire logic   i_rst_n,
   input  wire logic   i_enq,
   input  wire tuple_t i_data,
   input  wire logic   i_deq,
   output tuple_t      o_data,
   output logic        o_empty,
   output logic        o_full,
   output logic        o_almost_full
);

   localparam logic [AW:0] DEPTH_CNT = (AW+1)'(DEPTH);
   localparam logic [AW:0] AF_LEVEL = (AW+1)'(DEPTH - FIFO_SLACK);
   localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);

   tuple_t mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0] count;
   logic wr_ok;
   logic rd_ok;

   assign wr_ok = i_enq && !o_full;
   assign rd_ok = i_deq && !o_empty;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // The head is visible before it is dequeued.
   assign o_data = mem[rd_ptr];
   assign o_empty = (count == '0);
   assign o_full = (count == DEPTH_CNT);
   assign o_almost_full = (count > AF_LEVEL);

endmodule

`default_nettype wire

// ==== common/merge_pkg.sv ====
`default_nettype none

package merge_pkg;

   // Tuple layout: the sort key sits in the low KEY_W bits.
   localparam int TUPLE_W = 64;
   localparam int KEY_W = 32;

   // Every internal FIFO has the same depth.
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW = 4;

   // The output FIFO must absorb both pipe stages and the tuple popped in the same cycle.
   localparam int FIFO_SLACK = 3;

   typedef logic [TUPLE_W-1:0] tuple_t;
   typedef logic [KEY_W-1:0] key_t;

   // Merge decision for one cycle.
   typedef enum logic [1:0] {
      SEL_NONE = 2'd0,
      SEL_A    = 2'd1,
      SEL_B    = 2'd2,
      SEL_END  = 2'd3
   } sel_e;

endpackage

`default_nettype wire
